// File: sim.f
src/rv_pkg.sv
src/rv_idu.sv
src/rv_ctrl.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_core.sv
verif/rv_core_assertions.sv
verif/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_rv_core \
    --Mdir obj_dir -o tb_rv_core

./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    exit 1
fi
exit 0

// File: verif/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;
    localparam int K_OP = 0, K_OPI = 1, K_LUI = 2, K_AUIPC = 3, K_BR = 4, K_JAL = 5;
    localparam int K_JALR = 6, K_ST = 7, K_LD = 8, K_X0 = 9, K_BAD = 10;
    localparam int TIMEOUT = 200;
    localparam logic [31:0] RES_ADDR = 32'h3F0;   // where load results are stored
    localparam logic [31:0] EBREAK_W = 32'h0010_0073;

    logic        clk, rst_n;
    logic [31:0] inst_addr, inst_data, mem_addr, mem_wdata, mem_rdata;
    logic [3:0]  mem_wmask;
    logic        mem_we, mem_re, halted, trap;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    // stimulus table, one row per check
    int          t_kind [$];
    logic [2:0]  t_f3 [$];
    bit          t_alt [$];
    logic [31:0] t_a [$];
    logic [31:0] t_b [$];
    bit          t_rnd [$];
    logic [31:0] t_addr [$];

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_mask [$];
    logic [31:0] exp_ld [$];
    logic        exp_trap;
    int          mismatch_cnt, timeout_cnt, other_cnt;

    rv_core #(.RESET_PC(32'h0)) dut (
        .clk(clk), .rst_n(rst_n), .inst_addr(inst_addr), .inst_data(inst_data),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_we(mem_we), .mem_re(mem_re), .mem_rdata(mem_rdata),
        .halted(halted), .trap(trap)
    );

    assign inst_data = imem[inst_addr[9:2]];
    assign mem_rdata = dmem[mem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (mem_we) begin
            if (mem_wmask[0]) dmem[mem_addr[9:2]][7:0]   = mem_wdata[7:0];
            if (mem_wmask[1]) dmem[mem_addr[9:2]][15:8]  = mem_wdata[15:8];
            if (mem_wmask[2]) dmem[mem_addr[9:2]][23:16] = mem_wdata[23:16];
            if (mem_wmask[3]) dmem[mem_addr[9:2]][31:24] = mem_wdata[31:24];
        end
    end

    function automatic logic [31:0] lane_bits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // compare each store and load against the next expected one
    always @(negedge clk) begin
        if (mem_we) begin
            if (exp_addr.size() == 0) begin
                $display("Unexpected store at time %0t to address %h", $time, mem_addr);
                other_cnt++;
            end else begin
                if (mem_addr !== exp_addr[0]) begin
                    $display("Mismatch at %0t: mem_addr got %h expected %h",
                             $time, mem_addr, exp_addr[0]);
                    mismatch_cnt++;
                end
                if (mem_wmask !== exp_mask[0]) begin
                    $display("Mismatch at %0t: mem_wmask got %b expected %b",
                             $time, mem_wmask, exp_mask[0]);
                    mismatch_cnt++;
                end
                if ((mem_wdata & lane_bits(exp_mask[0])) !==
                    (exp_data[0] & lane_bits(exp_mask[0]))) begin
                    $display("Mismatch at %0t: mem_wdata got %h expected %h",
                             $time, mem_wdata, exp_data[0]);
                    mismatch_cnt++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_mask.pop_front());
            end
        end
        if (mem_re) begin
            if (exp_ld.size() == 0) begin
                $display("Unexpected load at time %0t from address %h", $time, mem_addr);
                other_cnt++;
            end else begin
                if (mem_addr !== exp_ld[0]) begin
                    $display("Mismatch at %0t: mem_addr got %h expected %h",
                             $time, mem_addr, exp_ld[0]);
                    mismatch_cnt++;
                end
                void'(exp_ld.pop_front());
            end
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic add_row(input int kind, input logic [2:0] f3, input bit alt,
                           input logic [31:0] a, input logic [31:0] b, input bit rnd,
                           input logic [31:0] addr);
        t_kind.push_back(kind);
        t_f3.push_back(f3);
        t_alt.push_back(alt);
        t_a.push_back(a);
        t_b.push_back(b);
        t_rnd.push_back(rnd);
        t_addr.push_back(addr);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] mask);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_mask.push_back(mask);
    endtask

    // program: x1 = a, x2 = b, operation under test at pc 16, then stores and ebreak
    task automatic assemble_row(input int r);
        logic [31:0] a, b, bi, addr, w, lw;
        logic [31:0] a_hi, b_hi;
        logic [11:0] imm12;
        logic [2:0]  f3;
        a = t_a[r];
        b = t_b[r];
        f3 = t_f3[r];
        addr = t_addr[r];
        if (t_rnd[r]) begin
            a = $urandom;
            b = $urandom;
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = EBREAK_W;
            dmem[i] = 32'(i) * 32'h9E37_79B1 + 32'h5A5A_0F0F;
        end
        a_hi = a + 32'h800;
        b_hi = b + 32'h800;
        imem[0] = {a_hi[31:12], 5'd1, 7'b0110111};
        imem[1] = enc_i(a[11:0], 5'd1, 3'd0, 5'd1, 7'b0010011);
        imem[2] = {b_hi[31:12], 5'd2, 7'b0110111};
        imem[3] = enc_i(b[11:0], 5'd2, 3'd0, 5'd2, 7'b0010011);
        imem[5] = enc_s(addr[11:0], 5'd3, 3'b010);
        exp_trap = 1'b0;
        case (t_kind[r])
            K_OP: begin
                imem[4] = enc_r(t_alt[r] ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3);
                expect_store(addr, alu_ref(f3, t_alt[r], a, b), 4'hF);
            end
            K_OPI: begin
                imm12 = (f3 == 3'd1 || f3 == 3'd5) ? {t_alt[r] ? 7'h20 : 7'h00, b[4:0]}
                                                   : b[11:0];
                bi = {{20{imm12[11]}}, imm12};
                imem[4] = enc_i(imm12, 5'd1, f3, 5'd3, 7'b0010011);
                expect_store(addr, alu_ref(f3, t_alt[r], a, bi), 4'hF);
            end
            K_LUI: begin
                imem[4] = {b[31:12], 5'd3, 7'b0110111};
                expect_store(addr, {b[31:12], 12'b0}, 4'hF);
            end
            K_AUIPC: begin
                imem[4] = {b[31:12], 5'd3, 7'b0010111};
                expect_store(addr, 32'd16 + {b[31:12], 12'b0}, 4'hF);
            end
            K_BR: begin
                imem[4] = enc_b(13'd12, f3);
                imem[5] = enc_i(12'h0AA, 5'd0, 3'd0, 5'd3, 7'b0010011);  // fall-through marker
                imem[6] = enc_j(21'd8, 5'd0);
                imem[7] = enc_i(12'h055, 5'd0, 3'd0, 5'd3, 7'b0010011);  // taken marker
                imem[8] = enc_s(addr[11:0], 5'd3, 3'b010);
                expect_store(addr, branch_ref(f3, a, b) ? 32'h55 : 32'hAA, 4'hF);
            end
            K_JAL, K_JALR: begin
                imem[4] = (t_kind[r] == K_JAL) ? enc_j(21'd8, 5'd3)
                                               : enc_i(12'd0, 5'd1, 3'd0, 5'd3, 7'b1100111);
                imem[5] = enc_i(12'h0AA, 5'd0, 3'd0, 5'd3, 7'b0010011);
                imem[6] = enc_s(addr[11:0], 5'd3, 3'b010);
                expect_store(addr, 32'd20, 4'hF);
            end
            K_ST: begin
                imem[4] = enc_s(addr[11:0], 5'd1, f3);
                imem[5] = EBREAK_W;
                if (f3 == 3'd0)
                    expect_store(addr, {4{a[7:0]}}, 4'b0001 << addr[1:0]);
                else
                    expect_store(addr, {2{a[15:0]}}, addr[1] ? 4'b1100 : 4'b0011);
            end
            K_LD: begin
                imem[4] = enc_i(addr[11:0], 5'd0, f3, 5'd3, 7'b0000011);
                imem[5] = enc_s(RES_ADDR[11:0], 5'd3, 3'b010);
                w = dmem[addr[9:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'd0:    lw = {{24{w[7]}}, w[7:0]};
                    3'd1:    lw = {{16{w[15]}}, w[15:0]};
                    3'd4:    lw = {24'b0, w[7:0]};
                    3'd5:    lw = {16'b0, w[15:0]};
                    default: lw = w;
                endcase
                exp_ld.push_back(addr);
                expect_store(RES_ADDR, lw, 4'hF);
            end
            K_X0: begin
                imem[4] = enc_i(12'h123, 5'd1, 3'd0, 5'd0, 7'b0010011);
                imem[5] = enc_s(addr[11:0], 5'd0, 3'b010);
                expect_store(addr, 32'h0, 4'hF);
            end
            default: begin
                imem[4] = 32'hFFFF_FFFF;  // no such opcode
                exp_trap = 1'b1;
            end
        endcase
    endtask

    initial begin
        int wait_cnt;
        rst_n = 1'b0;
        mismatch_cnt = 0;
        timeout_cnt = 0;
        other_cnt = 0;
        void'($urandom(59845));
        add_row(K_OP, 3'd0, 0, 0, 0, 1, 32'h100);
        add_row(K_OP, 3'd0, 1, 0, 0, 1, 32'h104);
        add_row(K_OP, 3'd1, 0, 32'h8000_00F1, 32'd35, 0, 32'h108);
        add_row(K_OP, 3'd2, 0, 0, 0, 1, 32'h10C);
        add_row(K_OP, 3'd2, 0, 32'hFFFF_FFF0, 32'd3, 0, 32'h110);
        add_row(K_OP, 3'd3, 0, 0, 0, 1, 32'h114);
        add_row(K_OP, 3'd3, 0, 32'hFFFF_FFF0, 32'd3, 0, 32'h118);
        add_row(K_OP, 3'd4, 0, 0, 0, 1, 32'h11C);
        add_row(K_OP, 3'd5, 0, 32'hF000_0000, 32'd7, 0, 32'h120);
        add_row(K_OP, 3'd5, 1, 0, 0, 1, 32'h124);
        add_row(K_OP, 3'd6, 0, 0, 0, 1, 32'h128);
        add_row(K_OP, 3'd7, 0, 0, 0, 1, 32'h12C);
        add_row(K_OPI, 3'd0, 0, 32'd1000, 32'hF85, 0, 32'h130);
        add_row(K_OPI, 3'd2, 0, 0, 0, 1, 32'h134);
        add_row(K_OPI, 3'd3, 0, 32'd5, 32'hFFF, 0, 32'h138);
        add_row(K_OPI, 3'd4, 0, 0, 0, 1, 32'h13C);
        add_row(K_OPI, 3'd6, 0, 0, 0, 1, 32'h140);
        add_row(K_OPI, 3'd7, 0, 0, 0, 1, 32'h144);
        add_row(K_OPI, 3'd1, 0, 0, 0, 1, 32'h148);
        add_row(K_OPI, 3'd5, 0, 32'h8765_4321, 32'd9, 0, 32'h14C);
        add_row(K_OPI, 3'd5, 1, 32'h8765_4321, 32'd9, 0, 32'h150);
        add_row(K_LUI, 3'd0, 0, 0, 32'hABCDE000, 0, 32'h154);
        add_row(K_AUIPC, 3'd0, 0, 0, 32'h12345000, 0, 32'h158);
        add_row(K_BR, 3'd0, 0, 32'd5, 32'd5, 0, 32'h15C);
        add_row(K_BR, 3'd0, 0, 32'd5, 32'd6, 0, 32'h160);
        add_row(K_BR, 3'd1, 0, 32'd5, 32'd6, 0, 32'h164);
        add_row(K_BR, 3'd4, 0, 32'hFFFF_FFFE, 32'd1, 0, 32'h168);
        add_row(K_BR, 3'd5, 0, 32'hFFFF_FFFE, 32'd1, 0, 32'h16C);
        add_row(K_BR, 3'd6, 0, 32'hFFFF_FFFE, 32'd1, 0, 32'h170);
        add_row(K_BR, 3'd7, 0, 32'hFFFF_FFFE, 32'd1, 0, 32'h174);
        add_row(K_JAL, 3'd0, 0, 0, 0, 0, 32'h178);
        add_row(K_JALR, 3'd0, 0, 32'd25, 0, 0, 32'h17C);
        add_row(K_ST, 3'd0, 0, 32'h1234_56C7, 0, 0, 32'h181);
        add_row(K_ST, 3'd0, 0, 32'h1234_56C7, 0, 0, 32'h187);
        add_row(K_ST, 3'd1, 0, 32'h89AB_CDEF, 0, 0, 32'h18A);
        add_row(K_ST, 3'd1, 0, 32'h89AB_CDEF, 0, 0, 32'h18C);
        add_row(K_LD, 3'd0, 0, 0, 0, 0, 32'h1C3);
        add_row(K_LD, 3'd4, 0, 0, 0, 0, 32'h1C3);
        add_row(K_LD, 3'd1, 0, 0, 0, 0, 32'h1D6);
        add_row(K_LD, 3'd5, 0, 0, 0, 0, 32'h1D6);
        add_row(K_LD, 3'd2, 0, 0, 0, 0, 32'h1E4);
        add_row(K_X0, 3'd0, 0, 0, 0, 1, 32'h1F0);
        add_row(K_BAD, 3'd0, 0, 0, 0, 0, 32'h1F4);

        for (int r = 0; r < t_kind.size(); r++) begin
            rst_n = 1'b0;
            assemble_row(r);
            repeat (4) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            wait_cnt = 0;
            while (!halted && wait_cnt < TIMEOUT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (!halted) begin
                $display("Timeout in row %0d: core never halted", r);
                timeout_cnt++;
            end
            repeat (4) @(negedge clk);  // any late store shows up here
            if (halted && trap !== exp_trap) begin
                $display("Mismatch at %0t: trap got %b expected %b", $time, trap, exp_trap);
                mismatch_cnt++;
            end
            if (exp_addr.size() != 0) begin
                $display("Row %0d ended with %0d expected stores missing", r, exp_addr.size());
                other_cnt++;
            end
            if (exp_ld.size() != 0) begin
                $display("Row %0d ended without the expected load strobe", r);
                other_cnt++;
            end
            exp_addr.delete();
            exp_data.delete();
            exp_mask.delete();
            exp_ld.delete();
        end

        $display("Errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatch_cnt, timeout_cnt, other_cnt);
        if (mismatch_cnt + timeout_cnt + other_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/rv_core_assertions.sv
`timescale 1ns/100ps

module rv_core_assertions (
    input logic clk,
    input logic rst_n,
    input logic mem_we,
    input logic mem_re,
    input logic halted,
    input logic trap
);
    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_we && mem_re))
        else $error("mem_we and mem_re high together");

    // first cycle out of reset is a fetch
    quiet_after_reset: assert property (@(posedge clk)
        (!rst_n ##1 rst_n) |-> (!mem_we && !mem_re))
        else $error("memory strobe high right after reset");

    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted dropped without reset");

    trap_halts: assert property (@(posedge clk) disable iff (!rst_n)
        trap |-> halted)
        else $error("trap high while core running");

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .mem_we(mem_we), .mem_re(mem_re),
    .halted(halted), .trap(trap)
);

// File: src/rv_core.sv
`timescale 1ns/100ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t inst_addr,
    input  rv_pkg::word_t inst_data,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic [3:0]    mem_wmask,
    output logic          mem_we,
    output logic          mem_re,
    input  rv_pkg::word_t mem_rdata,
    output logic          halted,
    output logic          trap
);
    rv_pkg::word_t       inst;
    rv_pkg::word_t       pc;
    rv_pkg::inst_class_t inst_class;
    rv_pkg::reg_idx_t    rd, rs1, rs2;
    rv_pkg::word_t       imm;
    rv_pkg::alu_op_t     alu_op;
    rv_pkg::funct3_t     funct3;
    logic                reg_write_en;
    logic                ctrl_reg_we;
    rv_pkg::word_t       rdata1, rdata2;
    rv_pkg::word_t       alu_a, alu_b;
    rv_pkg::word_t       alu_result;
    logic                branch_taken;
    rv_pkg::word_t       load_data;
    rv_pkg::word_t       wb_data;

    rv_ctrl #(.RESET_PC(RESET_PC)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .inst_data(inst_data), .inst_class(inst_class),
        .imm(imm), .alu_result(alu_result), .branch_taken(branch_taken),
        .inst_addr(inst_addr), .inst(inst), .pc(pc), .reg_we(ctrl_reg_we),
        .mem_we(mem_we), .mem_re(mem_re), .halted(halted), .trap(trap)
    );

    rv_idu u_idu (
        .inst(inst), .inst_class(inst_class), .rd(rd), .rs1(rs1), .rs2(rs2),
        .imm(imm), .alu_op(alu_op), .funct3(funct3), .reg_write_en(reg_write_en)
    );

    rv_regfile u_regfile (
        .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .we(ctrl_reg_we && reg_write_en),
        .wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
    );

    assign alu_a = (inst_class == rv_pkg::AUIPC || inst_class == rv_pkg::JAL) ? pc : rdata1;
    // only op and branch take rs2, the rest work on the immediate
    assign alu_b = (inst_class == rv_pkg::OP || inst_class == rv_pkg::BRANCH) ? rdata2 : imm;

    rv_alu u_alu (
        .alu_op(alu_op), .a(alu_a), .b(alu_b), .funct3(funct3),
        .result(alu_result), .branch_taken(branch_taken)
    );

    rv_lsu u_lsu (
        .funct3(funct3), .addr(alu_result), .store_data(rdata2), .mem_rdata(mem_rdata),
        .mem_wdata(mem_wdata), .mem_wmask(mem_wmask), .load_data(load_data)
    );

    assign mem_addr = alu_result;  // rs1 + imm for loads and stores

    always_comb begin
        case (inst_class)
            rv_pkg::LUI:               wb_data = imm;
            rv_pkg::JAL, rv_pkg::JALR: wb_data = pc + 32'd4; // link
            rv_pkg::LOAD:              wb_data = load_data;
            default:                   wb_data = alu_result;
        endcase
    end

endmodule

// File: src/rv_lsu.sv
`timescale 1ns/100ps

module rv_lsu (
    input  rv_pkg::funct3_t funct3,
    input  rv_pkg::word_t   addr,
    input  rv_pkg::word_t   store_data,
    input  rv_pkg::word_t   mem_rdata,
    output rv_pkg::word_t   mem_wdata,
    output logic [3:0]      mem_wmask,
    output rv_pkg::word_t   load_data
);
    logic [1:0]    offset;
    rv_pkg::word_t lane;  // addressed bytes moved to bit 0

    assign offset = addr[1:0];
    assign lane   = mem_rdata >> {offset, 3'b000};

    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                mem_wdata = {4{store_data[7:0]}};
                mem_wmask = 4'b0001 << offset;
            end
            2'b01: begin
                mem_wdata = {2{store_data[15:0]}};
                mem_wmask = offset[1] ? 4'b1100 : 4'b0011;
            end
            2'b10: begin
                mem_wdata = store_data;
                mem_wmask = 4'b1111;
            end
            default: begin
                mem_wdata = store_data;
                mem_wmask = 4'b0000;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};    // lb
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};  // lh
            3'b100:  load_data = {24'b0, lane[7:0]};            // lbu
            3'b101:  load_data = {16'b0, lane[15:0]};           // lhu
            default: load_data = mem_rdata;
        endcase
    end

endmodule

// File: src/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
    input  rv_pkg::alu_op_t alu_op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::funct3_t funct3,
    output rv_pkg::word_t   result,
    output logic            branch_taken
);
    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign eq    = a == b;
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (alu_op)
            rv_pkg::ADD:  result = a + b;
            rv_pkg::SUB:  result = a - b;
            rv_pkg::SLL:  result = a << shamt;
            rv_pkg::SLT:  result = {31'b0, lt_s};
            rv_pkg::SLTU: result = {31'b0, lt_u};
            rv_pkg::XOR:  result = a ^ b;
            rv_pkg::SRL:  result = a >> shamt;
            rv_pkg::SRA:  result = $unsigned($signed(a) >>> shamt);
            rv_pkg::OR:   result = a | b;
            rv_pkg::AND:  result = a & b;
            default:      result = '0;
        endcase
    end

    // compares share the slt/sltu comparators
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = eq;     // beq
            3'b001:  branch_taken = !eq;    // bne
            3'b100:  branch_taken = lt_s;   // blt
            3'b101:  branch_taken = !lt_s;  // bge
            3'b110:  branch_taken = lt_u;   // bltu
            3'b111:  branch_taken = !lt_u;  // bgeu
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             we,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);
    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;  // x0 is hardwired
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: src/rv_ctrl.sv
`timescale 1ns/100ps

module rv_ctrl #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_pkg::word_t       inst_data,
    input  rv_pkg::inst_class_t inst_class,
    input  rv_pkg::word_t       imm,
    input  rv_pkg::word_t       alu_result,
    input  logic                branch_taken,
    output rv_pkg::word_t       inst_addr,
    output rv_pkg::word_t       inst,
    output rv_pkg::word_t       pc,
    output logic                reg_we,
    output logic                mem_we,
    output logic                mem_re,
    output logic                halted,
    output logic                trap
);
    rv_pkg::ctrl_state_t state;
    rv_pkg::word_t       next_pc;
    logic                stop;
    logic                is_mem;

    assign stop   = inst_class == rv_pkg::EBREAK || inst_class == rv_pkg::INVALID;
    assign is_mem = inst_class == rv_pkg::LOAD || inst_class == rv_pkg::STORE;

    always_comb begin
        if (inst_class == rv_pkg::JAL ||
            (inst_class == rv_pkg::BRANCH && branch_taken)) begin
            next_pc = pc + imm;
        end else if (inst_class == rv_pkg::JALR) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rv_pkg::FETCH;
            pc    <= RESET_PC;
            trap  <= 1'b0;
        end else begin
            case (state)
                rv_pkg::FETCH: state <= rv_pkg::EXEC;
                rv_pkg::EXEC: begin
                    if (stop) begin
                        state <= rv_pkg::HALT;
                        trap  <= inst_class == rv_pkg::INVALID;
                    end else if (is_mem) begin
                        state <= rv_pkg::MEM;  // pc moves after the access
                    end else begin
                        pc    <= next_pc;
                        state <= rv_pkg::FETCH;
                    end
                end
                rv_pkg::MEM: begin
                    pc    <= next_pc;
                    state <= rv_pkg::FETCH;
                end
                default: state <= rv_pkg::HALT; // parked until reset
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state == rv_pkg::FETCH) begin
            inst <= inst_data;
        end
    end

    assign inst_addr = pc;
    assign halted    = state == rv_pkg::HALT;

    // loads write back in MEM, everything else in EXEC
    assign reg_we = (state == rv_pkg::EXEC && !is_mem && !stop) ||
                    (state == rv_pkg::MEM && inst_class == rv_pkg::LOAD);
    assign mem_we = state == rv_pkg::MEM && inst_class == rv_pkg::STORE;
    assign mem_re = state == rv_pkg::MEM && inst_class == rv_pkg::LOAD;

endmodule

// File: src/rv_idu.sv
`timescale 1ns/100ps

module rv_idu (
    input  rv_pkg::word_t       inst,
    output rv_pkg::inst_class_t inst_class,
    output rv_pkg::reg_idx_t    rd,
    output rv_pkg::reg_idx_t    rs1,
    output rv_pkg::reg_idx_t    rs2,
    output rv_pkg::word_t       imm,
    output rv_pkg::alu_op_t     alu_op,
    output rv_pkg::funct3_t     funct3,
    output logic                reg_write_en
);
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;   // 0100000, selects sub and sra
    rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode  = inst[6:0];
    assign funct7  = inst[31:25];
    assign funct3  = inst[14:12];
    assign rd      = inst[11:7];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign f7_zero = funct7 == 7'b0000000;
    assign f7_alt  = funct7 == 7'b0100000;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        inst_class = rv_pkg::INVALID;
        case (opcode)
            OPC_LUI:    inst_class = rv_pkg::LUI;
            OPC_AUIPC:  inst_class = rv_pkg::AUIPC;
            OPC_JAL:    inst_class = rv_pkg::JAL;
            OPC_JALR:   if (funct3 == 3'b000) inst_class = rv_pkg::JALR;
            OPC_BRANCH: if (funct3[2:1] != 2'b01) inst_class = rv_pkg::BRANCH;
            OPC_LOAD:   if (funct3 != 3'b011 && funct3[2:1] != 2'b11) inst_class = rv_pkg::LOAD;
            OPC_STORE:  if (!funct3[2] && funct3 != 3'b011) inst_class = rv_pkg::STORE;
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    if (f7_zero) inst_class = rv_pkg::OP_IMM;
                end else if (funct3 == 3'b101) begin
                    if (f7_zero || f7_alt) inst_class = rv_pkg::OP_IMM;
                end else begin
                    inst_class = rv_pkg::OP_IMM;
                end
            end
            OPC_OP: begin
                if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))
                    inst_class = rv_pkg::OP;
            end
            OPC_SYSTEM: if (inst == 32'h0010_0073) inst_class = rv_pkg::EBREAK; // ecall, csr rejected
            default: ;
        endcase
    end

    always_comb begin
        case (inst_class)
            rv_pkg::LUI, rv_pkg::AUIPC:                  imm = imm_u;
            rv_pkg::JAL:                                 imm = imm_j;
            rv_pkg::JALR, rv_pkg::LOAD, rv_pkg::OP_IMM:  imm = imm_i;
            rv_pkg::STORE:                               imm = imm_s;
            rv_pkg::BRANCH:                              imm = imm_b;
            default:                                     imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ADD; // address and link arithmetic
        if (inst_class == rv_pkg::OP || inst_class == rv_pkg::OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (inst_class == rv_pkg::OP && funct7[5]) ? rv_pkg::SUB
                                                                           : rv_pkg::ADD;
                3'b001:  alu_op = rv_pkg::SLL;
                3'b010:  alu_op = rv_pkg::SLT;
                3'b011:  alu_op = rv_pkg::SLTU;
                3'b100:  alu_op = rv_pkg::XOR;
                3'b101:  alu_op = funct7[5] ? rv_pkg::SRA : rv_pkg::SRL;
                3'b110:  alu_op = rv_pkg::OR;
                default: alu_op = rv_pkg::AND;
            endcase
        end
    end

    assign reg_write_en = inst_class inside {rv_pkg::LUI, rv_pkg::AUIPC, rv_pkg::JAL,
                                             rv_pkg::JALR, rv_pkg::LOAD, rv_pkg::OP_IMM,
                                             rv_pkg::OP};

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;    // instructions, addresses, register values, immediates
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;  // branch condition or load/store width and sign

    typedef enum logic [3:0] {
        LUI     = 4'd0,
        AUIPC   = 4'd1,
        JAL     = 4'd2,
        JALR    = 4'd3,
        BRANCH  = 4'd4,
        LOAD    = 4'd5,
        STORE   = 4'd6,
        OP_IMM  = 4'd7,
        OP      = 4'd8,
        EBREAK  = 4'd9,
        INVALID = 4'd15 // anything the decoder rejects
    } inst_class_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_t;

    // sequencing of the multi-cycle core
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } ctrl_state_t;

endpackage
